//--- compile.f
src/rvPkg.sv
src/rvDecode.sv
src/rvRegFile.sv
src/rvAlu.sv
src/rvLoadStore.sv
src/rvWriteback.sv
src/rvFetchPc.sv
src/rvCore.sv
sim/rvCoreProperties.sv
sim/rvCoreTb.sv

//--- sim/rvCoreTb.sv
// Testbench for the RV32E core
// Runs a fixed program from a behavioral memory under random wai
// stalls and checks every store against a table of expected writes
module rvCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int numStores = 8;

	logic         clk;
	logic         reset;
	logic         wai = 1'b0;
	logic         fetch, vma;
	logic [3:0]   wstrb;
	rvPkg::pc_t   addr;
	rvPkg::word_t wdata, rdata;
	rvPkg::word_t mem [256];	// Program at 0, results at 0x200, load source at 0x300
	logic [15:0]  lfsr = 16'd81;
	int           nextWord = 0;
	int           storeIdx = 0;
	int           storeErrors = 0;
	int           cycles = 0;	// Enabled cycles only, stalls extend the limit
	int           cycleLimit;

	// Expected stores in program order, word byte address, data, strobes
	logic [11:0]  expAddr [numStores] = '{12'h200, 12'h204, 12'h208, 12'h20C,
		12'h210, 12'h214, 12'h218, 12'h21C};
	rvPkg::word_t expData [numStores] = '{32'h3171_5003, 32'h0000_1029, 32'h0000_0300,
		32'hFFFD_0000, 32'hFFFF_7F67, 32'hFFFF_8000, 32'h0000_0074, 32'h0000_007C};
	logic [3:0]   expStrb [numStores] = '{4'hF, 4'hF, 4'h2, 4'hC, 4'hF, 4'hF, 4'hF, 4'hF};

	rvCore rvCore_inst (
		.clk(clk), .reset(reset), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.rdata(rdata), .fetch(fetch), .wai(wai), .vma(vma));

	bind rvCore rvCoreProperties props (.*);

	//////////////////////////////
	// Instruction encoders
	//////////////////////////////
	function automatic rvPkg::word_t rType(logic [6:0] f7, logic [2:0] f3,
		logic [4:0] rd, rs1, rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rvPkg::word_t iType(logic [6:0] op, logic [2:0] f3,
		logic [4:0] rd, rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};	// ALU immediate, loads, JALR
	endfunction

	function automatic rvPkg::word_t sType(logic [2:0] f3, logic [4:0] rs2, rs1,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rvPkg::word_t bType(logic [2:0] f3, logic [4:0] rs1, rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rvPkg::word_t jType(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic rvPkg::word_t uType(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, op};	// LUI, AUIPC
	endfunction

	task automatic put(rvPkg::word_t w);
		mem[nextWord] <= w;
		nextWord++;
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic rvPkg::word_t laneMask(logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	//////////////////////////////
	// Clock, stalls, memory
	//////////////////////////////
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Two fresh bits per cycle, stall about one cycle in four
	always @(posedge clk) begin
		if (reset)
			wai <= 1'b0;
		else begin
			lfsr = lfsrStep(lfsrStep(lfsr));
			wai <= lfsr[1] & lfsr[0];
		end
	end

	assign rdata = mem[addr[7:0]];	// Combinational read

	always @(posedge clk) begin
		if (!reset && !wai)
			for (int i = 0; i < 4; i++)
				if (wstrb[i])
					mem[addr[7:0]][8*i +: 8] <= wdata[8*i +: 8];
	end

	always @(posedge clk) begin
		if (!reset && !wai)
			cycles++;
	end

	// Every store, in order, against the table
	always @(posedge clk) begin
		if (!reset && !wai && wstrb != 4'b0000) begin
			if (storeIdx >= numStores) begin
				storeErrors++;
				$display("FAIL %0t: store beyond the table to 0x%h", $time, {addr, 2'b00});
			end else begin
				assert ({addr, 2'b00} == {20'b0, expAddr[storeIdx]} &&
					wstrb == expStrb[storeIdx] &&
					(wdata & laneMask(expStrb[storeIdx])) == expData[storeIdx])
				else begin
					storeErrors++;
					$display("FAIL %0t: store %0d wrote 0x%h strb %b to 0x%h", $time,
						storeIdx, wdata, wstrb, {addr, 2'b00});
				end
			end
			storeIdx++;
		end
	end

	//////////////////////////////
	// Program and run
	//////////////////////////////
	initial begin
		reset = 1'b1;
		for (int i = 0; i < 256; i++)
			mem[i] <= 32'hA5A5_0000 | i;	// Fill differs in every word
		mem[8'hC0] <= 32'h80F6_7F91;		// Load source at 0x300
		put(iType(7'h13, 0, 1, 0, 12'hFFD));	// 00 addi x1, x0, -3
		put(uType(7'h37, 2, 20'h12345));		// 04 lui x2
		put(rType(7'h20, 0, 3, 2, 1));			// 08 sub x3, x2, x1
		put(iType(7'h13, 5, 4, 1, 12'h401));	// 0C srai x4, x1, 1
		put(rType(7'h00, 5, 5, 1, 4));			// 10 srl x5, x1, x4, shift 30
		put(iType(7'h13, 1, 6, 2, 12'h004));	// 14 slli x6, x2, 4
		put(rType(7'h00, 4, 3, 3, 6));			// 18 xor x3, x3, x6
		put(rType(7'h00, 3, 7, 5, 1));			// 1C sltu x7, x5, x1
		put(rType(7'h00, 2, 8, 5, 1));			// 20 slt x8, x5, x1
		put(rType(7'h20, 0, 7, 7, 8));			// 24 sub x7, x7, x8
		put(uType(7'h17, 9, 20'h00001));		// 28 auipc x9, 1
		put(rType(7'h00, 0, 9, 9, 7));			// 2C add x9, x9, x7
		put(sType(2, 3, 0, 12'h200));			// 30 sw x3
		put(sType(2, 9, 0, 12'h204));			// 34 sw x9
		put(sType(0, 5, 0, 12'h209));			// 38 sb x5 into lane 1
		put(sType(1, 1, 0, 12'h20E));			// 3C sh x1 into upper half
		put(iType(7'h03, 0, 10, 0, 12'h300));	// 40 lb
		put(iType(7'h03, 5, 11, 0, 12'h302));	// 44 lhu
		put(rType(7'h00, 4, 10, 10, 11));		// 48 xor
		put(iType(7'h03, 4, 12, 0, 12'h302));	// 4C lbu
		put(iType(7'h03, 1, 13, 0, 12'h302));	// 50 lh
		put(rType(7'h00, 4, 12, 12, 13));		// 54 xor
		put(sType(2, 10, 0, 12'h210));			// 58 sw x10
		put(sType(2, 12, 0, 12'h214));			// 5C sw x12
		put(bType(1, 7, 8, 13'd8));				// 60 bne x7, x8, taken
		put(sType(2, 1, 0, 12'h218));			// 64 skipped
		put(bType(5, 5, 1, 13'd8));				// 68 bge x5, x1, taken
		put(sType(2, 1, 0, 12'h218));			// 6C skipped
		put(jType(14, 21'd8));					// 70 jal x14
		put(sType(2, 1, 0, 12'h218));			// 74 skipped
		put(iType(7'h67, 0, 15, 14, 12'h010));	// 78 jalr x15, 16(x14)
		put(sType(2, 1, 0, 12'h218));			// 7C skipped
		put(sType(2, 1, 0, 12'h218));			// 80 skipped
		put(sType(2, 14, 0, 12'h218));			// 84 sw x14, link of jal
		put(sType(2, 15, 0, 12'h21C));			// 88 sw x15, link of jalr
		put(jType(0, 21'd0));					// 8C spin here
		cycleLimit = 4 * nextWord;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (storeIdx < numStores && cycles < cycleLimit)
			@(negedge clk);
		repeat (20) @(negedge clk);	// Spin loop must stay quiet
		if (storeIdx < numStores)
			$display("Timeout: only %0d of %0d stores seen", storeIdx, numStores);
		$display("Store errors %0d, assertion errors %0d, stores seen %0d of %0d",
			storeErrors, rvCore_inst.props.errCount, storeIdx, numStores);
		if (storeErrors == 0 && rvCore_inst.props.errCount == 0 && storeIdx == numStores)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- sim/rvCoreProperties.sv
// Bus checks for the RV32E core
// Bound into the core: reset state, hold under wai, the bubble
// after a taken jump and the shape of store cycles
module rvCoreProperties (
	input logic            clk,
	input logic            reset,
	input rvPkg::pc_t      addr,
	input rvPkg::word_t    wdata,
	input logic [3:0]      wstrb,
	input logic            fetch,
	input logic            wai,
	input logic            vma,
	input rvPkg::opClass_t cls,
	input logic            taken
);
	timeunit 1ns;
	timeprecision 1ps;

	int errCount = 0;	// Summed into the closing line

	// First cycle out of reset is a fetch from the reset address
	resetFetch: assert property (@(posedge clk) $fell(reset) |->
		addr == rvPkg::resetPc[31:2] && fetch && vma && wstrb == 4'b0000)
	else begin
		errCount++;
		$error("FAIL %0t: first access after reset is not a fetch from resetPc", $time);
	end

	// Memory stall freezes the whole port
	holdOnWai: assert property (@(posedge clk) disable iff (reset)
		wai |=> $stable(addr) && $stable(wdata) && $stable(wstrb) && $stable(fetch))
	else begin
		errCount++;
		$error("FAIL %0t: bus outputs changed while wai was high", $time);
	end

	// Taken jump drops its fetch, then the bubble fetches for real
	jumpBubble: assert property (@(posedge clk) disable iff (reset)
		(cls.jal || cls.jalr || taken) && !wai |=> vma)
	else begin
		errCount++;
		$error("FAIL %0t: vma low for more than one cycle after a jump", $time);
	end

	// A real fetch is decoded next, a dropped one never is
	fetchDecoded: assert property (@(posedge clk) disable iff (reset)
		fetch && !wai |=> cls.valid == $past(vma))
	else begin
		errCount++;
		$error("FAIL %0t: decode of the fetched word does not follow vma", $time);
	end

	// Strobes only on a data cycle, one lane, a half or the word
	storeShape: assert property (@(posedge clk) disable iff (reset)
		wstrb != 4'b0000 |-> !fetch && vma && wstrb inside
		{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
	else begin
		errCount++;
		$error("FAIL %0t: bad store cycle, wstrb %b fetch %b", $time, wstrb, fetch);
	end

endmodule

//--- src/rvCore.sv
// RV32E two-stage core, top level
// Fetch overlaps execute; loads, stores and taken jumps cost one
// extra cycle. Memory port is word addressed with wai/vma handshake
module rvCore (
	input  logic         clk,
	input  logic         reset,
	output rvPkg::pc_t   addr,
	output rvPkg::word_t wdata,
	output logic [3:0]   wstrb,
	input  rvPkg::word_t rdata,
	output logic         fetch,		// Low on the data cycle of a load or store
	input  logic         wai,		// Memory stall
	output logic         vma		// Real access this cycle
);

	logic            clkEn;
	rvPkg::opClass_t cls;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	rvPkg::regAddr_t rd, rs1, rs2;
	rvPkg::word_t    immI, immS, immB, immJ, immU;
	rvPkg::word_t    rs1Data, rs2Data;
	rvPkg::word_t    aluResult, rdData;
	logic [1:0]      addLow;
	logic            taken, rdWrite;
	rvPkg::pc_t      dataAddr, pc, pcCurrent;

	//////////////////////////////
	// Clock enable and bus
	//////////////////////////////
	assign clkEn = ~wai;	// Only stall source

	assign addr  = cls.mem ? dataAddr : pc;
	assign fetch = ~cls.mem;
	assign vma   = ~(cls.jal | cls.jalr | taken);	// Word fetched here is dropped

	//////////////////////////////
	// Stages
	//////////////////////////////
	rvDecode u_decode (
		.clk(clk), .reset(reset), .clkEn(clkEn), .rdata(rdata), .taken(taken),
		.cls(cls), .funct3(funct3), .funct7(funct7), .rd(rd), .rs1(rs1), .rs2(rs2),
		.immI(immI), .immS(immS), .immB(immB), .immJ(immJ), .immU(immU));

	rvRegFile u_regFile (
		.clk(clk), .clkEn(clkEn), .rs1(rs1), .rs2(rs2), .rd(rd),
		.rdWrite(rdWrite), .rdData(rdData), .rs1Data(rs1Data), .rs2Data(rs2Data));

	rvAlu u_alu (
		.cls(cls), .funct3(funct3), .funct7(funct7), .rs1Data(rs1Data),
		.rs2Data(rs2Data), .immI(immI), .immS(immS), .immU(immU),
		.pcCurrent(pcCurrent), .aluResult(aluResult), .addLow(addLow), .taken(taken));

	rvLoadStore u_loadStore (
		.cls(cls), .funct3(funct3), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.immI(immI), .immS(immS), .dataAddr(dataAddr), .wdata(wdata), .wstrb(wstrb));

	rvWriteback u_writeback (
		.cls(cls), .funct3(funct3), .addLow(addLow), .rdata(rdata),
		.aluResult(aluResult), .pc(pc), .rdWrite(rdWrite), .rdData(rdData));

	rvFetchPc u_fetchPc (
		.clk(clk), .reset(reset), .clkEn(clkEn), .cls(cls), .immB(immB),
		.immJ(immJ), .taken(taken), .aluResult(aluResult), .pc(pc),
		.pcCurrent(pcCurrent));

endmodule

//--- src/rvFetchPc.sv
// Program counter
// PC runs one word ahead of the executing instruction; a second
// register keeps the current instruction's address
module rvFetchPc (
	input  logic            clk,
	input  logic            reset,
	input  logic            clkEn,
	input  rvPkg::opClass_t cls,
	input  rvPkg::word_t    immB,
	input  rvPkg::word_t    immJ,
	input  logic            taken,
	input  rvPkg::word_t    aluResult,
	output rvPkg::pc_t      pc,
	output rvPkg::pc_t      pcCurrent
);

	rvPkg::pc_t pcImm;
	rvPkg::pc_t pcRel;		// Branch or JAL target
	rvPkg::pc_t pcSeq;		// Same or incremented PC
	rvPkg::pc_t pcNext;

	assign pcImm = taken ? immB[31:2] : (cls.jal ? immJ[31:2] : '0);
	assign pcRel = pcCurrent + pcImm;
	assign pcSeq = pc + (cls.mem ? 30'd0 : 30'd1);	// Hold over the data cycle

	// JALR target straight from the ALU adder
	assign pcNext = cls.jalr ? aluResult[31:2] : ((cls.jal | taken) ? pcRel : pcSeq);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc        <= rvPkg::resetPc[31:2];
			pcCurrent <= rvPkg::resetPc[31:2];
		end else if (clkEn) begin
			pc        <= pcNext;
			pcCurrent <= pc;	// Address of the word now being fetched
		end
	end

endmodule

//--- src/rvWriteback.sv
// Register write-back
// Picks the loaded lane with sign or zero extension, then selects
// between ALU result, load data and link address
module rvWriteback (
	input  rvPkg::opClass_t cls,
	input  logic [2:0]      funct3,
	input  logic [1:0]      addLow,
	input  rvPkg::word_t    rdata,
	input  rvPkg::word_t    aluResult,
	input  rvPkg::pc_t      pc,			// Already one word ahead
	output logic            rdWrite,
	output rvPkg::word_t    rdData
);

	logic [15:0]  loadHalf;
	logic [7:0]   loadByte;
	logic         loadSign;
	rvPkg::word_t loadData;

	//////////////////////////////
	// Load extraction
	//////////////////////////////
	assign loadHalf = addLow[1] ? rdata[31:16] : rdata[15:0];
	assign loadByte = addLow[0] ? loadHalf[15:8] : loadHalf[7:0];

	// funct3 bit 2 set for LBU and LHU
	assign loadSign = ~funct3[2] &
		((funct3[1:0] == rvPkg::sizeByte) ? loadByte[7] : loadHalf[15]);

	always_comb begin
		case (funct3[1:0])
			rvPkg::sizeByte: loadData = {{24{loadSign}}, loadByte};
			rvPkg::sizeHalf: loadData = {{16{loadSign}}, loadHalf};
			default:         loadData = rdata;	// Full word
		endcase
	end

	//////////////////////////////
	// Write select
	//////////////////////////////
	assign rdData = cls.load ? loadData :
		((cls.jal | cls.jalr) ? {pc, 2'b00} : aluResult);	// Link is jump + 4

	// Stores and branches leave the bank alone
	assign rdWrite = cls.regOp | cls.immOp | cls.load | cls.jal |
		cls.jalr | cls.lui | cls.auipc;

endmodule

//--- src/rvLoadStore.sv
// Load/store address and store data path
// Own address adder, store lane replication and byte strobes
module rvLoadStore (
	input  rvPkg::opClass_t cls,
	input  logic [2:0]      funct3,
	input  rvPkg::word_t    rs1Data,
	input  rvPkg::word_t    rs2Data,
	input  rvPkg::word_t    immI,
	input  rvPkg::word_t    immS,
	output rvPkg::pc_t      dataAddr,
	output rvPkg::word_t    wdata,
	output logic [3:0]      wstrb
);

	rvPkg::word_t byteAddr;

	// Separate adder keeps the bus address off the ALU path
	assign byteAddr = rs1Data + (cls.load ? immI : immS);
	assign dataAddr = byteAddr[31:2];

	// Source byte or halfword copied into every lane it can land in
	assign wdata[7:0]   = rs2Data[7:0];
	assign wdata[15:8]  = byteAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
	assign wdata[23:16] = byteAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
	assign wdata[31:24] = byteAddr[0] ? rs2Data[7:0] :
		(byteAddr[1] ? rs2Data[15:8] : rs2Data[31:24]);

	// Strobes only on a store
	always_comb begin
		wstrb = 4'b0000;
		if (cls.store) begin
			case (funct3[1:0])
				rvPkg::sizeByte: wstrb = 4'b0001 << byteAddr[1:0];
				rvPkg::sizeHalf: wstrb = byteAddr[1] ? 4'b1100 : 4'b0011;
				rvPkg::sizeWord: wstrb = 4'b1111;
				default:         wstrb = 4'b0000;	// Reserved size
			endcase
		end
	end

endmodule

//--- src/rvAlu.sv
// Integer ALU
// One 33-bit adder for add, subtract and all compares, a five
// layer barrel shifter, result select and branch predicate
module rvAlu (
	input  rvPkg::opClass_t cls,
	input  logic [2:0]      funct3,
	input  logic [6:0]      funct7,
	input  rvPkg::word_t    rs1Data,
	input  rvPkg::word_t    rs2Data,
	input  rvPkg::word_t    immI,
	input  rvPkg::word_t    immS,
	input  rvPkg::word_t    immU,
	input  rvPkg::pc_t      pcCurrent,
	output rvPkg::word_t    aluResult,
	output logic [1:0]      addLow,		// Byte offset of a load
	output logic            taken
);

	rvPkg::word_t aluIn1, aluIn2;
	logic         isSub, selAdd;
	logic [32:0]  aluAdder;
	logic         lt, ltu, eq;
	logic         leftSh, signedSh;
	rvPkg::word_t shIn, shT1, shT2, shT3, shT4, shT5, shOut;
	logic [7:0]   predList;

	function automatic rvPkg::word_t reverseBits(input rvPkg::word_t x);
		rvPkg::word_t r;
		for (int i = 0; i < rvPkg::xlen; i++)
			r[i] = x[rvPkg::xlen-1-i];
		return r;
	endfunction

	//////////////////////////////
	// Operands and adder
	//////////////////////////////
	assign aluIn1 = cls.lui ? '0 : (cls.auipc ? {pcCurrent, 2'b00} : rs1Data);

	always_comb begin
		if (cls.regOp | cls.branch)
			aluIn2 = rs2Data;
		else if (cls.immOp | cls.load | cls.jalr)
			aluIn2 = immI;
		else if (cls.store)
			aluIn2 = immS;
		else
			aluIn2 = immU;	// LUI, AUIPC, bubbles
	end

	// SUB, SLT(I), SLT(I)U and every branch compare
	assign isSub = (cls.regOp & (funct7[5] | (funct3 == rvPkg::f3Slt) |
		(funct3 == rvPkg::f3Sltu))) |
		(cls.immOp & ((funct3 == rvPkg::f3Slt) | (funct3 == rvPkg::f3Sltu))) |
		cls.branch;

	assign aluAdder = {isSub, (isSub ? ~aluIn2 : aluIn2)} + {1'b0, aluIn1} + 33'(isSub);
	assign ltu = aluAdder[32];	// Borrow
	assign lt  = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluAdder[32];
	assign eq  = (aluAdder[31:0] == '0);
	assign addLow = aluAdder[1:0];

	//////////////////////////////
	// Barrel shifter
	//////////////////////////////
	// Left shifts run through the right shifter bit-reversed
	assign leftSh   = (cls.regOp | cls.immOp) & (funct3 == rvPkg::f3Sll);
	assign signedSh = (cls.regOp | cls.immOp) & (funct3 == rvPkg::f3Srl) & funct7[5];

	assign shIn = leftSh ? reverseBits(aluIn1) : aluIn1;
	assign shT1 = aluIn2[4] ? {{16{signedSh & shIn[31]}}, shIn[31:16]} : shIn;
	assign shT2 = aluIn2[3] ? {{8{signedSh & shT1[31]}}, shT1[31:8]} : shT1;
	assign shT3 = aluIn2[2] ? {{4{signedSh & shT2[31]}}, shT2[31:4]} : shT2;
	assign shT4 = aluIn2[1] ? {{2{signedSh & shT3[31]}}, shT3[31:2]} : shT3;
	assign shT5 = aluIn2[0] ? {signedSh & shT4[31], shT4[31:1]} : shT4;
	assign shOut = leftSh ? reverseBits(shT5) : shT5;	// Undo the reversal

	//////////////////////////////
	// Result select
	//////////////////////////////
	// Address forming classes always want the sum
	assign selAdd = cls.lui | cls.auipc | cls.jalr | cls.load | cls.store;

	always_comb begin
		if (selAdd)
			aluResult = aluAdder[31:0];
		else begin
			case (funct3)
				rvPkg::f3Add:  aluResult = aluAdder[31:0];
				rvPkg::f3Sll:  aluResult = shOut;
				rvPkg::f3Slt:  aluResult = {31'b0, lt};
				rvPkg::f3Sltu: aluResult = {31'b0, ltu};
				rvPkg::f3Xor:  aluResult = aluIn1 ^ aluIn2;
				rvPkg::f3Srl:  aluResult = shOut;
				rvPkg::f3Or:   aluResult = aluIn1 | aluIn2;
				rvPkg::f3And:  aluResult = aluIn1 & aluIn2;
			endcase
		end
	end

	// Branch condition indexed by funct3, codes 2 and 3 unused
	assign predList = {~ltu, ltu, ~lt, lt, 2'b00, ~eq, eq};
	assign taken    = cls.branch & predList[funct3];

endmodule

//--- src/rvRegFile.sv
// Register bank
// Sixteen 32-bit registers, two asynchronous read ports and one
// write port, x0 hardwired to zero
module rvRegFile (
	input  logic            clk,
	input  logic            clkEn,
	input  rvPkg::regAddr_t rs1,
	input  rvPkg::regAddr_t rs2,
	input  rvPkg::regAddr_t rd,
	input  logic            rdWrite,
	input  rvPkg::word_t    rdData,
	output rvPkg::word_t    rs1Data,
	output rvPkg::word_t    rs2Data
);

	rvPkg::word_t regs [rvPkg::numRegs];	// Entry 0 never written

	logic [rvPkg::regAddrBits-1:0] rs1Idx;
	logic [rvPkg::regAddrBits-1:0] rs2Idx;
	logic [rvPkg::regAddrBits-1:0] rdIdx;

	// RV32E only decodes the low four bits
	assign rs1Idx = rs1[rvPkg::regAddrBits-1:0];
	assign rs2Idx = rs2[rvPkg::regAddrBits-1:0];
	assign rdIdx  = rd[rvPkg::regAddrBits-1:0];

	// x0 reads zero
	assign rs1Data = (rs1Idx != '0) ? regs[rs1Idx] : '0;
	assign rs2Data = (rs2Idx != '0) ? regs[rs2Idx] : '0;

	// Written at the end of the execute cycle
	always_ff @(posedge clk) begin
		if (clkEn && rdWrite && (rdIdx != '0))
			regs[rdIdx] <= rdData;
	end

endmodule

//--- src/rvDecode.sv
// Instruction decode stage
// Holds the instruction register and its valid flag, splits the
// opcode fields and builds the five immediate formats
module rvDecode (
	input  logic             clk,
	input  logic             reset,
	input  logic             clkEn,
	input  rvPkg::word_t     rdata,
	input  logic             taken,		// Conditional branch taken this cycle
	output rvPkg::opClass_t  cls,
	output logic [2:0]       funct3,
	output logic [6:0]       funct7,
	output rvPkg::regAddr_t  rd,
	output rvPkg::regAddr_t  rs1,
	output rvPkg::regAddr_t  rs2,
	output rvPkg::word_t     immI,
	output rvPkg::word_t     immS,
	output rvPkg::word_t     immB,
	output rvPkg::word_t     immJ,
	output rvPkg::word_t     immU
);

	rvPkg::word_t ir;		// Instruction register
	logic         valid;
	logic [6:0]   opcode;

	//////////////////////////////
	// Instruction register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (clkEn)
			ir <= rdata;	// Also loads data words, flagged invalid below
	end

	// Word fetched under a load, store or taken jump is not an opcode
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			valid <= 1'b0;
		else if (clkEn)
			valid <= ~(cls.load | cls.store | cls.jal | cls.jalr | taken);
	end

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	// Register fields forced to x0 on a bubble
	assign rd  = valid ? ir[11:7]  : 5'd0;
	assign rs1 = valid ? ir[19:15] : 5'd0;
	assign rs2 = valid ? ir[24:20] : 5'd0;

	//////////////////////////////
	// Opcode classes
	//////////////////////////////
	assign cls.valid  = valid;
	assign cls.regOp  = valid & (opcode == rvPkg::opReg);
	assign cls.immOp  = valid & (opcode == rvPkg::opImm);
	assign cls.load   = valid & (opcode == rvPkg::opLoad);
	assign cls.store  = valid & (opcode == rvPkg::opStore);
	assign cls.branch = valid & (opcode == rvPkg::opBranch);
	assign cls.jal    = valid & (opcode == rvPkg::opJal);
	assign cls.jalr   = valid & (opcode == rvPkg::opJalr);
	assign cls.lui    = valid & (opcode == rvPkg::opLui);
	assign cls.auipc  = valid & (opcode == rvPkg::opAuipc);
	assign cls.mem    = cls.load | cls.store;	// Takes the bus next

	//////////////////////////////
	// Immediates
	//////////////////////////////
	// Sign always comes from bit 31
	assign immI = {{21{ir[31]}}, ir[30:20]};
	assign immS = {{21{ir[31]}}, ir[30:25], ir[11:7]};
	assign immB = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign immJ = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
	assign immU = {ir[31:12], 12'b0};	// Upper 20 bits, low part zero

endmodule

//--- src/rvPkg.sv
// RV32E core definitions
// Data and address types, major opcodes, ALU function codes,
// access size codes and the decoded opcode class flags
package rvPkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////
	localparam int xlen        = 32;	// Data word width
	localparam int numRegs     = 16;	// RV32E register count
	localparam int regAddrBits = 4;		// Bank index bits
	localparam int pcBits      = 30;	// Word address, two low bits dropped

	typedef logic [xlen-1:0]   word_t;
	typedef logic [pcBits-1:0] pc_t;		// Word address
	typedef logic [4:0]        regAddr_t;	// Full register field from the opcode

	localparam word_t resetPc = 32'h0000_0000;	// Byte address of first fetch

	//////////////////////////////
	// Major opcodes
	//////////////////////////////
	localparam logic [6:0] opReg    = 7'b0110011;	// rd = rs1 op rs2
	localparam logic [6:0] opImm    = 7'b0010011;	// rd = rs1 op imm
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;

	// ALU function codes (funct3)
	localparam logic [2:0] f3Add  = 3'd0;	// Also SUB with funct7 bit 5
	localparam logic [2:0] f3Sll  = 3'd1;
	localparam logic [2:0] f3Slt  = 3'd2;
	localparam logic [2:0] f3Sltu = 3'd3;
	localparam logic [2:0] f3Xor  = 3'd4;
	localparam logic [2:0] f3Srl  = 3'd5;	// Also SRA
	localparam logic [2:0] f3Or   = 3'd6;
	localparam logic [2:0] f3And  = 3'd7;

	// Access size in funct3[1:0], bit 2 selects zero extension
	localparam logic [1:0] sizeByte = 2'b00;
	localparam logic [1:0] sizeHalf = 2'b01;
	localparam logic [1:0] sizeWord = 2'b10;

	//////////////////////////////
	// Decoded opcode classes
	//////////////////////////////
	// All class flags are already qualified by valid
	typedef struct packed {
		logic valid;	// Instruction register holds a real opcode
		logic regOp;
		logic immOp;
		logic load;
		logic store;
		logic branch;
		logic jal;
		logic jalr;
		logic lui;
		logic auipc;
		logic mem;		// Load or store, data cycle on the bus
	} opClass_t;

endpackage
